// ==== rom_pkg.sv ====
//####################
// rom fetch package
// shared widths, client ids, arbiter states
// and the request bundle a client hands to the arbiter
//####################

package rom_pkg;

    // sdram geometry
    localparam int sdram_aw  = 22;  // word address, 32-bit words
    localparam int sdram_dw  = 32;  // one sdram word per fetch
    localparam int n_clients = 4;   // main, char, scr, obj

    // client identity, listed in priority order
    // highest priority first, none means no grant held
    // load strobe bit for a client is its value minus one
    typedef enum logic [2:0] {
        client_none = 3'd0,
        client_scr  = 3'd1,   // scroll tiles, lvbl gated
        client_obj  = 3'd2,   // sprites, never gated
        client_main = 3'd3,   // cpu code, chip select gated
        client_char = 3'd4    // text layer, lvbl gated
    } client_e;

    // arbiter FSM
    typedef enum logic {
        st_idle = 1'b0,   // free to grant
        st_wait = 1'b1    // waiting for ack and data
    } arb_state_e;

    // miss request from one client
    // word is relative to the client region, offset added later
    typedef struct packed {
        logic                req;
        logic [sdram_aw-1:0] word;
    } rom_req_t;

endpackage

// ==== rom_client.sv ====
//####################
// rom client cache
// two 32-bit entries per client, alternate replacement
// serves 8/16-bit reads and raises a miss request
//####################

`timescale 1ns/1ps

module rom_client #(
    parameter int addr_w    = 18,    // client byte/halfword address width
    parameter int data_w    = 16,    // 8 for the cpu, 16 for video
    parameter bit invert_a0 = 1'b0   // swap lanes for the cpu byte order
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [addr_w-1:0]            addr,
    input  logic                         addr_ok,
    input  logic [rom_pkg::sdram_dw-1:0] din,
    input  logic                         load,
    output logic [data_w-1:0]            dout,
    output logic                         data_ok,
    output rom_pkg::rom_req_t            rq
);

    // low address bits select the slice inside a 32-bit word
    localparam int sh    = (data_w == 8) ? 2 : 1;
    localparam int tag_w = addr_w - sh;

    logic [tag_w-1:0]             cur_tag;
    logic [sh-1:0]                lane;
    logic [tag_w-1:0]             tag [2];
    logic [rom_pkg::sdram_dw-1:0] mem [2];
    logic [1:0]                   valid;
    logic                         nxt;       // entry replaced on next load
    logic [1:0]                   hit;
    logic [rom_pkg::sdram_dw-1:0] word_sel;

    assign cur_tag = addr[addr_w-1:sh];   // sdram word within the region

    // tag compare against both entries
    assign hit[0] = valid[0] && (tag[0] == cur_tag);
    assign hit[1] = valid[1] && (tag[1] == cur_tag);

    // miss request, stays up until the load fills an entry
    // the address is expected to hold still while the miss is pending
    assign rq.req  = addr_ok && !(|hit);
    assign rq.word = {{(rom_pkg::sdram_aw - tag_w){1'b0}}, cur_tag};

    always_comb begin
        lane    = addr[sh-1:0];
        lane[0] = lane[0] ^ invert_a0;   // cpu sees swapped lanes
    end

    // fresh sdram data bypasses the entries on the load cycle
    always_comb begin
        if (load) begin
            word_sel = din;
        end else if (hit[1]) begin
            word_sel = mem[1];
        end else begin
            word_sel = mem[0];
        end
    end

    // control state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid   <= 2'b00;   // all entries empty
            nxt     <= 1'b0;
            data_ok <= 1'b0;
        end else begin
            data_ok <= addr_ok && (load || (|hit));   // valid one cycle after hit or fill
            if (load) begin
                valid[nxt] <= 1'b1;
                nxt        <= ~nxt;   // round robin between the two
            end
        end
    end

    // entry payload and output slice
    always_ff @(posedge clk) begin
        if (load) begin
            tag[nxt] <= cur_tag;
            mem[nxt] <= din;
        end
        if (load || (|hit)) begin
            dout <= word_sel[lane*data_w +: data_w];
        end
    end

endmodule

// ==== rom_arbiter.sv ====
//####################
// rom request arbiter
// fixed priority grant, region offset add, sdram strobes
// also runs the ready delay and refresh enable
//####################

`timescale 1ns/1ps

module rom_arbiter #(
    parameter logic [rom_pkg::sdram_aw-1:0] scr_offset  = 22'h02_4000,
    parameter logic [rom_pkg::sdram_aw-1:0] obj_offset  = 22'h04_c000,
    parameter logic [rom_pkg::sdram_aw-1:0] main_offset = 22'h00_0000,
    parameter logic [rom_pkg::sdram_aw-1:0] char_offset = 22'h01_8000
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           lvbl,
    input  logic                           downloading,
    input  logic                           loop_rst,
    input  rom_pkg::rom_req_t              scr_rq,
    input  rom_pkg::rom_req_t              obj_rq,
    input  rom_pkg::rom_req_t              main_rq,
    input  rom_pkg::rom_req_t              char_rq,
    output logic [rom_pkg::n_clients-1:0]  load,
    output logic                           sdram_req,
    input  logic                           sdram_ack,
    input  logic                           data_rdy,
    output logic [rom_pkg::sdram_aw-1:0]   sdram_addr,
    output logic                           refresh_en,
    output logic                           ready
);

    rom_pkg::arb_state_e          state;
    rom_pkg::client_e             sel;         // client owning the transaction
    rom_pkg::client_e             grant_sel;
    logic [rom_pkg::sdram_aw-1:0] grant_off;
    logic [rom_pkg::sdram_aw-1:0] grant_word;
    logic                         clear;
    logic                         grant;
    logic [2:0]                   ready_sr;    // ready delay line

    assign clear = downloading || loop_rst;   // rom being rewritten or loop restart

    // pick the highest priority pending miss
    always_comb begin
        grant_sel  = rom_pkg::client_none;
        grant_off  = '0;
        grant_word = '0;
        if (scr_rq.req) begin
            grant_sel  = rom_pkg::client_scr;
            grant_off  = scr_offset;
            grant_word = scr_rq.word;
        end else if (obj_rq.req) begin
            grant_sel  = rom_pkg::client_obj;
            grant_off  = obj_offset;
            grant_word = obj_rq.word;
        end else if (main_rq.req) begin
            grant_sel  = rom_pkg::client_main;
            grant_off  = main_offset;
            grant_word = main_rq.word;
        end else if (char_rq.req) begin
            grant_sel  = rom_pkg::client_char;
            grant_off  = char_offset;
            grant_word = char_rq.word;
        end
    end

    // new transaction only from idle and outside a clear
    assign grant = (state == rom_pkg::st_idle) && !clear
                   && (grant_sel != rom_pkg::client_none);

    // load strobe follows data_rdy for the selected client
    always_comb begin
        for (int i = 0; i < rom_pkg::n_clients; i++) begin
            load[i] = (state == rom_pkg::st_wait) && data_rdy && (int'(sel) == i + 1);
        end
    end

    // transaction FSM
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= rom_pkg::st_idle;
            sel       <= rom_pkg::client_none;
            sdram_req <= 1'b0;
        end else if (clear) begin
            state     <= rom_pkg::st_idle;   // drop whatever was in flight
            sel       <= rom_pkg::client_none;
            sdram_req <= 1'b0;
        end else begin
            case (state)
                rom_pkg::st_idle: begin
                    if (grant) begin
                        sel       <= grant_sel;
                        sdram_req <= 1'b1;
                        state     <= rom_pkg::st_wait;
                    end
                end
                rom_pkg::st_wait: begin
                    if (sdram_ack) begin
                        sdram_req <= 1'b0;   // controller took the request
                    end
                    if (data_rdy) begin
                        sel   <= rom_pkg::client_none;
                        state <= rom_pkg::st_idle;   // free again next cycle
                    end
                end
                default: state <= rom_pkg::st_idle;
            endcase
        end
    end

    // address held from grant to next grant
    always_ff @(posedge clk) begin
        if (grant) begin
            sdram_addr <= grant_off + grant_word;
        end
    end

    // ready rises four cycles after reset or clear ends
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ready_sr <= 3'b000;
            ready    <= 1'b0;
        end else if (clear) begin
            ready_sr <= 3'b000;
            ready    <= 1'b0;
        end else begin
            {ready, ready_sr} <= {ready_sr, 1'b1};   // shift ones toward ready
        end
    end

    // refresh only while the screen is blanked
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            refresh_en <= 1'b0;
        end else begin
            refresh_en <= !lvbl;
        end
    end

endmodule

// ==== rom_subsys.sv ====
//####################
// rom fetch subsystem
// four client caches sharing one sdram through
// a fixed priority arbiter
//####################

`timescale 1ns/1ps

module rom_subsys #(
    // region start per client, in sdram words
    parameter logic [rom_pkg::sdram_aw-1:0] main_offset = 22'h00_0000,  // cpu code
    parameter logic [rom_pkg::sdram_aw-1:0] char_offset = 22'h01_8000,  // text tiles
    parameter logic [rom_pkg::sdram_aw-1:0] scr_offset  = 22'h02_4000,  // scroll tiles
    parameter logic [rom_pkg::sdram_aw-1:0] obj_offset  = 22'h04_c000,  // sprites
    // client address widths
    parameter int main_aw = 18,   // byte address
    parameter int char_aw = 14,   // 16-bit address
    parameter int scr_aw  = 17,
    parameter int obj_aw  = 17
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         lvbl,
    input  logic                         main_cs,

    // client reads
    input  logic [main_aw-1:0]           main_addr,
    input  logic [char_aw-1:0]           char_addr,
    input  logic [scr_aw-1:0]            scr_addr,
    input  logic [obj_aw-1:0]            obj_addr,
    output logic [7:0]                   main_dout,
    output logic [15:0]                  char_dout,
    output logic [15:0]                  scr_dout,
    output logic [15:0]                  obj_dout,
    output logic                         main_ok,
    output logic                         char_ok,
    output logic                         scr_ok,
    output logic                         obj_ok,

    output logic                         ready,
    output logic                         refresh_en,

    // sdram controller side
    output logic                         sdram_req,
    output logic [rom_pkg::sdram_aw-1:0] sdram_addr,
    input  logic                         sdram_ack,
    input  logic                         data_rdy,
    input  logic                         downloading,
    input  logic                         loop_rst,
    input  logic [rom_pkg::sdram_dw-1:0] data_read
);

    rom_pkg::rom_req_t              main_rq;
    rom_pkg::rom_req_t              char_rq;
    rom_pkg::rom_req_t              scr_rq;
    rom_pkg::rom_req_t              obj_rq;
    logic [rom_pkg::n_clients-1:0]  load;   // one hot, bit per client id minus one

    // cpu code, byte wide, only while selected
    rom_client #(
        .addr_w    (main_aw),
        .data_w    (8),
        .invert_a0 (1'b1)
    ) u_main (
        .clk     (clk),
        .rst_n   (rst_n),
        .addr    (main_addr),
        .addr_ok (main_cs),
        .din     (data_read),
        .load    (load[int'(rom_pkg::client_main) - 1]),
        .dout    (main_dout),
        .data_ok (main_ok),
        .rq      (main_rq)
    );

    // text layer, fetched during active video
    rom_client #(
        .addr_w    (char_aw),
        .data_w    (16),
        .invert_a0 (1'b0)
    ) u_char (
        .clk     (clk),
        .rst_n   (rst_n),
        .addr    (char_addr),
        .addr_ok (lvbl),
        .din     (data_read),
        .load    (load[int'(rom_pkg::client_char) - 1]),
        .dout    (char_dout),
        .data_ok (char_ok),
        .rq      (char_rq)
    );

    rom_client #(
        .addr_w    (scr_aw),
        .data_w    (16),
        .invert_a0 (1'b0)
    ) u_scr (
        .clk     (clk),
        .rst_n   (rst_n),
        .addr    (scr_addr),
        .addr_ok (lvbl),
        .din     (data_read),
        .load    (load[int'(rom_pkg::client_scr) - 1]),
        .dout    (scr_dout),
        .data_ok (scr_ok),
        .rq      (scr_rq)
    );

    // sprites also draw in blanking, never gated
    rom_client #(
        .addr_w    (obj_aw),
        .data_w    (16),
        .invert_a0 (1'b0)
    ) u_obj (
        .clk     (clk),
        .rst_n   (rst_n),
        .addr    (obj_addr),
        .addr_ok (1'b1),
        .din     (data_read),
        .load    (load[int'(rom_pkg::client_obj) - 1]),
        .dout    (obj_dout),
        .data_ok (obj_ok),
        .rq      (obj_rq)
    );

    rom_arbiter #(
        .scr_offset  (scr_offset),
        .obj_offset  (obj_offset),
        .main_offset (main_offset),
        .char_offset (char_offset)
    ) u_arb (
        .clk         (clk),
        .rst_n       (rst_n),
        .lvbl        (lvbl),
        .downloading (downloading),
        .loop_rst    (loop_rst),
        .scr_rq      (scr_rq),
        .obj_rq      (obj_rq),
        .main_rq     (main_rq),
        .char_rq     (char_rq),
        .load        (load),
        .sdram_req   (sdram_req),
        .sdram_ack   (sdram_ack),
        .data_rdy    (data_rdy),
        .sdram_addr  (sdram_addr),
        .refresh_en  (refresh_en),
        .ready       (ready)
    );

endmodule

// ==== tb_sdram_model.sv ====
//####################
// behavioral sdram responder
// ack after one cycle, data after a random 2 to 5 more
// word contents follow from the address
//####################

`timescale 1ns/1ps

module tb_sdram_model (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         sdram_req,
    input  logic [rom_pkg::sdram_aw-1:0] sdram_addr,
    output logic                         sdram_ack,
    output logic                         data_rdy,
    output logic [rom_pkg::sdram_dw-1:0] data_read,
    output int                           req_count
);

    logic                         busy;       // between ack and data
    logic [rom_pkg::sdram_aw-1:0] addr_q;
    logic [2:0]                   wait_cnt;
    logic [31:0]                  rnd;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            addr_q    <= '0;
            wait_cnt  <= '0;
            rnd       <= 32'h8a2c_2c8e;
            sdram_ack <= 1'b0;
            data_rdy  <= 1'b0;
            data_read <= '0;
            req_count <= 0;
        end else begin
            sdram_ack <= 1'b0;   // both strobes last one cycle
            data_rdy  <= 1'b0;
            if (!busy) begin
                if (sdram_req) begin
                    sdram_ack <= 1'b1;
                    addr_q    <= sdram_addr;
                    rnd       <= xorshift32(rnd);
                    wait_cnt  <= 3'd1 + 3'(rnd[1:0]);   // data 2..5 cycles after ack
                    busy      <= 1'b1;
                    req_count <= req_count + 1;
                end
            end else if (wait_cnt != 3'd0) begin
                wait_cnt <= wait_cnt - 3'd1;
            end else begin
                data_rdy  <= 1'b1;
                data_read <= {addr_q[15:0] ^ 16'h5a5a, addr_q[15:0]};
                busy      <= 1'b0;
            end
        end
    end

endmodule

// ==== tb_rom_assert.sv ====
//####################
// arbiter protocol checks
// sdram strobe timing and load strobe rules
//####################

`timescale 1ns/1ps

module tb_rom_assert (
    input logic                          clk,
    input logic                          rst_n,
    input rom_pkg::arb_state_e           state,
    input logic                          sdram_req,
    input logic                          sdram_ack,
    input logic                          data_rdy,
    input logic [rom_pkg::n_clients-1:0] load,
    input logic [rom_pkg::sdram_aw-1:0]  sdram_addr
);

    int fail_count = 0;   // summed into the testbench result

    // ack takes the request down next cycle
    a_req_drop: assert property (@(posedge clk) disable iff (!rst_n)
        sdram_req && sdram_ack |=> !sdram_req)
        else begin
            $error("sdram_req still high the cycle after sdram_ack");
            fail_count++;
        end

    // returned data reaches exactly one client, never several
    a_load_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(load) && (!(data_rdy && state == rom_pkg::st_wait) || $onehot(load)))
        else begin
            $error("load strobes not one hot for the returned data");
            fail_count++;
        end

    // a load only with data, after the request was taken down
    a_load_rdy: assert property (@(posedge clk) disable iff (!rst_n)
        |load |-> data_rdy && !sdram_req)
        else begin
            $error("load strobe without data_rdy or with sdram_req still high");
            fail_count++;
        end

    a_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        sdram_req |=> !sdram_req || $stable(sdram_addr))
        else begin
            $error("sdram_addr moved while sdram_req was high");
            fail_count++;
        end

endmodule

// ==== tb_rom_subsys.sv ====
//####################
// rom fetch subsystem testbench
// directed reads on all four clients against a behavioral sdram
//####################

`timescale 1ns/1ps

module tb_rom_subsys;

    localparam logic [21:0] main_off = 22'h00_0000;
    localparam logic [21:0] char_off = 22'h01_8000;
    localparam logic [21:0] scr_off  = 22'h02_4000;
    localparam logic [21:0] obj_off  = 22'h04_c000;

    logic        clk;
    logic        rst_n;
    logic        lvbl;
    logic        main_cs;
    logic        downloading;
    logic        loop_rst;
    logic [17:0] main_addr;
    logic [13:0] char_addr;
    logic [16:0] scr_addr;
    logic [16:0] obj_addr;
    logic [7:0]  main_dout;
    logic [15:0] char_dout, scr_dout, obj_dout;
    logic        main_ok, char_ok, scr_ok, obj_ok;
    logic        ready, refresh_en, sdram_req, sdram_ack, data_rdy, req_d;
    logic [21:0] sdram_addr;
    logic [31:0] data_read;
    int          req_count;
    int          errors;
    logic [21:0] addr_log [$];   // sdram_addr of every new request

    rom_subsys #(
        .main_offset (main_off),
        .char_offset (char_off),
        .scr_offset  (scr_off),
        .obj_offset  (obj_off)
    ) i_rom_subsys (.*);

    tb_sdram_model i_sdram_model (.*);

    bind rom_arbiter tb_rom_assert i_rom_assert (.*);

    always #4 clk = ~clk;

    // a rising sdram_req marks one grant
    always @(negedge clk) begin
        if (sdram_req && !req_d) begin
            addr_log.push_back(sdram_addr);
        end
        req_d <= sdram_req;
    end

    // sdram word address and data slice a client read should return
    task automatic expect_read(input rom_pkg::client_e c, input logic [17:0] a,
                               output logic [21:0] ea, output logic [15:0] ed);
        logic [31:0] w;
        logic [1:0]  lane;
        case (c)
            rom_pkg::client_main: ea = main_off + 22'(a >> 2);   // byte client
            rom_pkg::client_char: ea = char_off + 22'(a >> 1);
            rom_pkg::client_scr:  ea = scr_off + 22'(a >> 1);
            default:              ea = obj_off + 22'(a >> 1);
        endcase
        w = {ea[15:0] ^ 16'h5a5a, ea[15:0]};
        lane = a[1:0] ^ 2'b01;   // cpu lanes swapped
        ed = (c == rom_pkg::client_main) ? {8'h00, w[lane*8 +: 8]} : (a[0] ? w[31:16] : w[15:0]);
    endtask

    task automatic set_addr(input rom_pkg::client_e c, input logic [17:0] a);
        case (c)
            rom_pkg::client_main: main_addr <= a;
            rom_pkg::client_char: char_addr <= a[13:0];
            rom_pkg::client_scr:  scr_addr  <= a[16:0];
            default:              obj_addr  <= a[16:0];
        endcase
    endtask

    function automatic logic [16:0] client_out(input rom_pkg::client_e c);
        case (c)
            rom_pkg::client_main: return {main_ok, 8'h00, main_dout};
            rom_pkg::client_char: return {char_ok, char_dout};
            rom_pkg::client_scr:  return {scr_ok, scr_dout};
            default:              return {obj_ok, obj_dout};
        endcase
    endfunction

    // wait for data_ok, compare dout and the logged request at idx (none for idx < 0)
    task automatic check_read(input string name, input rom_pkg::client_e c,
                              input logic [17:0] a, input int idx);
        logic [21:0] ea;
        logic [15:0] ed;
        logic [16:0] got;
        expect_read(c, a, ea, ed);
        got = '0;
        @(posedge clk);   // data_ok of the old address still up here
        for (int i = 0; i < 100 && !got[16]; i++) begin
            @(negedge clk);
            got = client_out(c);
        end
        if (!got[16]) begin
            $display("%s: %s gave no data_ok within 100 cycles", name, c.name());
            errors++;
        end else if (got[15:0] != ed) begin
            $display("[FAIL] %s: dout expected %h, got %h", name, ed, got[15:0]);
            errors++;
        end
        if (idx >= 0 && addr_log[idx] !== ea) begin
            $display("[FAIL] %s: sdram_addr expected %h, got %h", name, ea, addr_log[idx]);
            errors++;
        end
    endtask

    task automatic read_client(input string name, input rom_pkg::client_e c,
                               input logic [17:0] a, input bit fetch);
        int idx;
        idx = fetch ? addr_log.size() : -1;
        @(posedge clk);
        set_addr(c, a);
        check_read(name, c, a, idx);
    endtask

    // count low cycles of ready after the releasing edge
    task automatic check_ready_delay(input string name);
        int n;
        for (n = 0; n < 20; n++) begin
            @(negedge clk);
            if (ready) break;
        end
        if (n != 4) begin
            $display("[FAIL] %s: ready low cycles expected 4, got %0d", name, n);
            errors++;
        end
    endtask

    // obj miss raised while clear is high must wait for the release
    task automatic clear_cycle(input string name, input bit use_loop, input logic [17:0] a);
        int idx;
        idx = addr_log.size();
        @(posedge clk);
        downloading <= !use_loop;
        loop_rst    <= use_loop;
        set_addr(rom_pkg::client_obj, a);
        repeat (6) @(negedge clk);
        if (ready || sdram_req || addr_log.size() != idx) begin
            $display("%s: ready or sdram_req active during the clear", name);
            errors++;
        end
        @(posedge clk);
        downloading <= 1'b0;
        loop_rst    <= 1'b0;
        check_ready_delay(name);
        check_read(name, rom_pkg::client_obj, a, idx);
    endtask

    task automatic reset_clear();
        repeat (7) @(posedge clk);
        @(negedge clk);
        if (sdram_req || ready) begin
            $display("reset: sdram_req or ready high during reset");
            errors++;
        end
        @(posedge clk);
        rst_n <= 1'b1;
        check_ready_delay("reset");
        check_read("reset_obj", rom_pkg::client_obj, 18'h0, 0);   // obj is never gated
        clear_cycle("download", 1'b0, 18'h0_0010);
        clear_cycle("loop_rst", 1'b1, 18'h0_0020);
    endtask

    task automatic fetch_per_client();
        int idx;
        read_client("fetch_obj", rom_pkg::client_obj, 18'h1_0006, 1'b1);
        idx = addr_log.size();
        @(posedge clk);
        main_cs <= 1'b1;
        set_addr(rom_pkg::client_main, 18'h0_1236);
        check_read("fetch_main", rom_pkg::client_main, 18'h0_1236, idx);
        idx = addr_log.size();
        @(posedge clk);
        lvbl <= 1'b1;   // opens scr and char together
        set_addr(rom_pkg::client_scr, 18'h0_1235);
        set_addr(rom_pkg::client_char, 18'h0_02a1);
        check_read("fetch_scr", rom_pkg::client_scr, 18'h0_1235, idx);
        check_read("fetch_char", rom_pkg::client_char, 18'h0_02a1, idx + 1);
    endtask

    task automatic cache_hits();
        int n;
        n = req_count;
        read_client("hit_main", rom_pkg::client_main, 18'h0_1234, 1'b0);
        read_client("hit_scr", rom_pkg::client_scr, 18'h0_1234, 1'b0);
        read_client("fill_scr", rom_pkg::client_scr, 18'h0_2000, 1'b1);
        read_client("hit_scr_other", rom_pkg::client_scr, 18'h0_1235, 1'b0);
        if (req_count != n + 1) begin
            $display("[FAIL] cache_hit: sdram requests expected %0d, got %0d", n + 1, req_count);
            errors++;
        end
    endtask

    task automatic priority_order();
        rom_pkg::client_e c [4];
        logic [17:0]      a [4];
        int               idx;
        c = '{rom_pkg::client_scr, rom_pkg::client_obj, rom_pkg::client_main,
              rom_pkg::client_char};
        a = '{18'h0_4002, 18'h0_0802, 18'h0_2008, 18'h0_0100};
        idx = addr_log.size();
        @(posedge clk);
        for (int i = 0; i < 4; i++) begin
            set_addr(c[i], a[i]);   // four misses in one cycle
        end
        for (int i = 0; i < 4; i++) begin
            check_read("priority", c[i], a[i], idx + i);
        end
    endtask

    task automatic gating_refresh();
        int n;
        int idx;
        n   = req_count;
        idx = addr_log.size();
        @(posedge clk);
        lvbl    <= 1'b0;
        main_cs <= 1'b0;
        set_addr(rom_pkg::client_scr, 18'h0_6000);
        set_addr(rom_pkg::client_char, 18'h0_0200);
        set_addr(rom_pkg::client_main, 18'h0_3000);
        set_addr(rom_pkg::client_obj, 18'h0_1000);
        check_read("gate_obj", rom_pkg::client_obj, 18'h0_1000, idx);
        repeat (20) @(negedge clk);   // window for stray requests
        if (req_count != n + 1) begin
            $display("[FAIL] gating: sdram requests expected %0d, got %0d", n + 1, req_count);
            errors++;
        end
        if (scr_ok || char_ok || main_ok) begin
            $display("gating: a gated client raised data_ok");
            errors++;
        end
        for (int k = 0; k < 2; k++) begin
            @(posedge clk);
            lvbl <= !lvbl;
            @(negedge clk);   // still the old level inverted
            if (refresh_en !== lvbl) begin
                $display("[FAIL] refresh: expected %b, got %b", lvbl, refresh_en);
                errors++;
            end
            @(negedge clk);
            if (refresh_en !== !lvbl) begin
                $display("[FAIL] refresh: expected %b, got %b", !lvbl, refresh_en);
                errors++;
            end
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        lvbl        = 1'b0;   // video clients closed at start
        main_cs     = 1'b0;
        downloading = 1'b0;
        loop_rst    = 1'b0;
        main_addr   = '0;
        char_addr   = '0;
        scr_addr    = '0;
        obj_addr    = '0;
        req_d       = 1'b0;
        errors      = 0;
        reset_clear();
        fetch_per_client();
        cache_hits();
        priority_order();
        gating_refresh();
        $display("errors %0d, assertion failures %0d", errors,
                 i_rom_subsys.u_arb.i_rom_assert.fail_count);
        if (errors == 0 && i_rom_subsys.u_arb.i_rom_assert.fail_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
rom_pkg.sv
rom_client.sv
rom_arbiter.sv
rom_subsys.sv
tb_sdram_model.sv
tb_rom_assert.sv
tb_rom_subsys.sv
